// File: src/adam_pkg.sv
package adam_pkg;

    // ********************
    // Bus widths
    // ********************

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8; // One strobe bit per byte lane

    // ********************
    // Memory map
    // ********************

    localparam int NO_MEMS       = 3;
    localparam int MEM_SIZE      = 32768;
    localparam int MEM_ADDR_BITS = $clog2(MEM_SIZE);

    // The select field sits right above the offset of one RAM
    localparam int SEL_LSB  = MEM_ADDR_BITS;
    localparam int SEL_BITS = 2;

    // ********************
    // Shared types
    // ********************

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]            resp_t;
    typedef logic [SEL_BITS-1:0]   sel_t;

    // AXI response codes, only the two used by this domain
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

// File: src/adam_axil_if.sv
`timescale 1ns/1ns

interface adam_axil_if;

    import adam_pkg::*;

    addr_t aw_addr;
    logic  aw_valid;
    logic  aw_ready;

    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;

    resp_t b_resp;
    logic  b_valid;
    logic  b_ready;

    addr_t ar_addr;
    logic  ar_valid;
    logic  ar_ready;

    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
    logic  r_ready;

    modport mst (
        output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
        output ar_addr, ar_valid, r_ready,
        input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
    );

    modport slv (
        input  aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
        input  ar_addr, ar_valid, r_ready,
        output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
    );

endinterface

// File: src/adam_axil_ram.sv
`timescale 1ns/1ns

module adam_axil_ram #(
    parameter int SIZE = adam_pkg::MEM_SIZE
) (
    input  logic     clk,
    input  logic     reset,

    adam_axil_if.slv slv
);

    import adam_pkg::*;

    localparam int WORDS    = SIZE / STRB_WIDTH;
    localparam int IDX_LSB  = $clog2(STRB_WIDTH);
    localparam int IDX_BITS = $clog2(WORDS);

    typedef logic [IDX_BITS-1:0] idx_t;

    // Contents start at zero
    data_t mem [WORDS] = '{default: '0};

    logic ready_q;
    logic write;
    logic read;
    idx_t w_idx;
    idx_t r_idx;

    // Only the offset bits address a word, everything above is ignored
    assign w_idx = slv.aw_addr[IDX_LSB +: IDX_BITS];
    assign r_idx = slv.ar_addr[IDX_LSB +: IDX_BITS];

    // ********************
    // Handshakes
    // ********************

    // Address and data are taken together, never one without the other
    assign slv.aw_ready = ready_q && !slv.b_valid && slv.w_valid;
    assign slv.w_ready  = ready_q && !slv.b_valid && slv.aw_valid;
    assign slv.ar_ready = ready_q && !slv.r_valid;

    assign write = slv.aw_valid && slv.aw_ready;
    assign read  = slv.ar_valid && slv.ar_ready;

    assign slv.b_resp = RESP_OKAY;
    assign slv.r_resp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q     <= 1'b0;
            slv.b_valid <= 1'b0;
            slv.r_valid <= 1'b0;
        end else begin
            ready_q <= 1'b1; // Readies come up one cycle after reset

            if (write) begin
                slv.b_valid <= 1'b1;
            end else if (slv.b_ready) begin
                slv.b_valid <= 1'b0;
            end

            if (read) begin
                slv.r_valid <= 1'b1;
            end else if (slv.r_ready) begin
                slv.r_valid <= 1'b0;
            end
        end
    end

    // ********************
    // Storage
    // ********************

    always_ff @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (slv.w_strb[b]) begin
                    mem[w_idx][8*b +: 8] <= slv.w_data[8*b +: 8];
                end
            end
        end
    end

    // A read in the same cycle as a write sees the old word
    always_ff @(posedge clk) begin
        if (read) begin
            slv.r_data <= mem[r_idx];
        end
    end

    b_held: assert property (@(posedge clk) disable iff (reset)
        slv.b_valid && !slv.b_ready |=> slv.b_valid)
        else $error("b_valid dropped before b_ready");

    r_held: assert property (@(posedge clk) disable iff (reset)
        slv.r_valid && !slv.r_ready |=> slv.r_valid && $stable(slv.r_data))
        else $error("r_valid or r_data changed before r_ready");

endmodule

// File: src/adam_axil_demux.sv
`timescale 1ns/1ns

module adam_axil_demux (
    input  logic     clk,
    input  logic     reset,

    adam_axil_if.slv slv,
    adam_axil_if.mst mst [adam_pkg::NO_MEMS],

    input  logic     pause_req,
    output logic     pause_ack
);

    import adam_pkg::*;

    sel_t aw_sel;
    sel_t ar_sel;
    logic aw_en;
    logic ar_en;

    logic w_busy;
    logic r_busy;
    sel_t w_tag;
    sel_t r_tag;

    // One slot per select value, slots past the RAMs answer with DECERR
    logic  aw_ready_s [2**SEL_BITS];
    logic  w_ready_s  [2**SEL_BITS];
    logic  b_valid_s  [2**SEL_BITS];
    resp_t b_resp_s   [2**SEL_BITS];
    logic  ar_ready_s [2**SEL_BITS];
    logic  r_valid_s  [2**SEL_BITS];
    data_t r_data_s   [2**SEL_BITS];
    resp_t r_resp_s   [2**SEL_BITS];

    logic [NO_MEMS-1:0] aw_valid_v;

    assign aw_sel = slv.aw_addr[SEL_LSB +: SEL_BITS];
    assign ar_sel = slv.ar_addr[SEL_LSB +: SEL_BITS];

    // New requests wait for the previous response and for the end of a pause
    assign aw_en = !w_busy && !pause_req && !pause_ack;
    assign ar_en = !r_busy && !pause_req && !pause_ack;

    // ********************
    // Routing
    // ********************

    for (genvar i = 0; i < 2**SEL_BITS; i++) begin : gen_slot
        if (i < NO_MEMS) begin : gen_mem
            assign mst[i].aw_addr  = slv.aw_addr;
            assign mst[i].aw_valid = aw_en && slv.aw_valid && (aw_sel == sel_t'(i));
            assign mst[i].w_data   = slv.w_data;
            assign mst[i].w_strb   = slv.w_strb;
            assign mst[i].w_valid  = aw_en && slv.w_valid && (aw_sel == sel_t'(i));
            assign mst[i].b_ready  = w_busy && slv.b_ready && (w_tag == sel_t'(i));

            assign mst[i].ar_addr  = slv.ar_addr;
            assign mst[i].ar_valid = ar_en && slv.ar_valid && (ar_sel == sel_t'(i));
            assign mst[i].r_ready  = r_busy && slv.r_ready && (r_tag == sel_t'(i));

            assign aw_ready_s[i] = mst[i].aw_ready;
            assign w_ready_s[i]  = mst[i].w_ready;
            assign b_valid_s[i]  = mst[i].b_valid;
            assign b_resp_s[i]   = mst[i].b_resp;
            assign ar_ready_s[i] = mst[i].ar_ready;
            assign r_valid_s[i]  = mst[i].r_valid;
            assign r_data_s[i]   = mst[i].r_data;
            assign r_resp_s[i]   = mst[i].r_resp;
            assign aw_valid_v[i] = mst[i].aw_valid;
        end else begin : gen_decerr
            // Accepts aw and w together, like a RAM does
            assign aw_ready_s[i] = slv.w_valid;
            assign w_ready_s[i]  = slv.aw_valid;
            assign b_valid_s[i]  = 1'b1; // Gated by w_busy, so it shows one cycle later
            assign b_resp_s[i]   = RESP_DECERR;
            assign ar_ready_s[i] = 1'b1;
            assign r_valid_s[i]  = 1'b1;
            assign r_data_s[i]   = '0;
            assign r_resp_s[i]   = RESP_DECERR;
        end
    end

    assign slv.aw_ready = aw_en && aw_ready_s[aw_sel];
    assign slv.w_ready  = aw_en && w_ready_s[aw_sel];
    assign slv.b_valid  = w_busy && b_valid_s[w_tag];
    assign slv.b_resp   = b_resp_s[w_tag];

    assign slv.ar_ready = ar_en && ar_ready_s[ar_sel];
    assign slv.r_valid  = r_busy && r_valid_s[r_tag];
    assign slv.r_data   = r_data_s[r_tag];
    assign slv.r_resp   = r_resp_s[r_tag];

    // ********************
    // Outstanding tracking
    // ********************

    always_ff @(posedge clk) begin
        if (reset) begin
            w_busy    <= 1'b0;
            r_busy    <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            if (slv.aw_valid && slv.aw_ready) begin
                w_busy <= 1'b1;
            end else if (slv.b_valid && slv.b_ready) begin
                w_busy <= 1'b0;
            end
            if (slv.ar_valid && slv.ar_ready) begin
                r_busy <= 1'b1;
            end else if (slv.r_valid && slv.r_ready) begin
                r_busy <= 1'b0;
            end
            pause_ack <= pause_req && !w_busy && !r_busy; // Quiet once both responses are gone
        end
    end

    always_ff @(posedge clk) begin
        if (slv.aw_valid && slv.aw_ready) begin
            w_tag <= aw_sel;
        end
        if (slv.ar_valid && slv.ar_ready) begin
            r_tag <= ar_sel;
        end
    end

    aw_one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0(aw_valid_v))
        else $error("aw_valid reaches more than one RAM");

    no_accept_paused: assert property (@(posedge clk) disable iff (reset)
        pause_ack |-> !(slv.aw_valid && slv.aw_ready) && !(slv.ar_valid && slv.ar_ready))
        else $error("Address accepted while the domain is paused");

endmodule

// File: src/adam_mem_sys.sv
`timescale 1ns/1ns

module adam_mem_sys (
    input  logic            clk,
    input  logic            reset,

    input  adam_pkg::addr_t aw_addr,
    input  logic            aw_valid,
    output logic            aw_ready,

    input  adam_pkg::data_t w_data,
    input  adam_pkg::strb_t w_strb,
    input  logic            w_valid,
    output logic            w_ready,

    output adam_pkg::resp_t b_resp,
    output logic            b_valid,
    input  logic            b_ready,

    input  adam_pkg::addr_t ar_addr,
    input  logic            ar_valid,
    output logic            ar_ready,

    output adam_pkg::data_t r_data,
    output adam_pkg::resp_t r_resp,
    output logic            r_valid,
    input  logic            r_ready,

    input  logic            pause_req,
    output logic            pause_ack
);

    import adam_pkg::*;

    adam_axil_if req_axil ();
    adam_axil_if mem_axil [NO_MEMS] ();

    // Requester side of the demux
    assign req_axil.aw_addr  = aw_addr;
    assign req_axil.aw_valid = aw_valid;
    assign aw_ready          = req_axil.aw_ready;

    assign req_axil.w_data   = w_data;
    assign req_axil.w_strb   = w_strb;
    assign req_axil.w_valid  = w_valid;
    assign w_ready           = req_axil.w_ready;

    assign b_resp            = req_axil.b_resp;
    assign b_valid           = req_axil.b_valid;
    assign req_axil.b_ready  = b_ready;

    assign req_axil.ar_addr  = ar_addr;
    assign req_axil.ar_valid = ar_valid;
    assign ar_ready          = req_axil.ar_ready;

    assign r_data            = req_axil.r_data;
    assign r_resp            = req_axil.r_resp;
    assign r_valid           = req_axil.r_valid;
    assign req_axil.r_ready  = r_ready;

    adam_axil_demux i_demux (
        .clk       (clk),
        .reset     (reset),
        .slv       (req_axil),
        .mst       (mem_axil),
        .pause_req (pause_req),
        .pause_ack (pause_ack)
    );

    for (genvar i = 0; i < NO_MEMS; i++) begin : gen_ram
        adam_axil_ram #(
            .SIZE (MEM_SIZE)
        ) i_ram (
            .clk   (clk),
            .reset (reset),
            .slv   (mem_axil[i])
        );
    end

endmodule

// File: test/adam_tb.sv
`timescale 1ns/1ns

module adam_tb;

    import adam_pkg::*;

    localparam int CYCLE_LIMIT = 20000;
    localparam int WAIT_LIMIT  = 64; // Longest wait for a single handshake
    localparam int UPPER_BITS  = ADDR_WIDTH - SEL_LSB - SEL_BITS;

    logic  clk = 1'b0;
    logic  reset;
    addr_t aw_addr, ar_addr;
    data_t w_data, r_data;
    strb_t w_strb;
    resp_t b_resp, r_resp;
    logic  aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic  ar_valid, ar_ready, r_valid, r_ready;
    logic  pause_req, pause_ack;

    int unsigned lcg_state = 28341;
    int          errors    = 0;
    int          err_mark  = 0;
    int          cycles    = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;
    logic [7:0]  model [int]; // Bytes written so far, keyed by select and offset

    adam_mem_sys dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("The run timed out after %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ********************
    // Random numbers and model
    // ********************

    function automatic int next_rand(input int n);
        lcg_state = lcg_state * 1103515245 + 12345;
        return int'(lcg_state[31:16]) % n; // Low bits of an LCG repeat too soon
    endfunction

    function automatic data_t rand_word();
        data_t w;
        w[31:16] = 16'(next_rand(65536));
        w[15:0]  = 16'(next_rand(65536));
        return w;
    endfunction

    function automatic addr_t make_addr(input int sel, input int off, input int upper);
        addr_t a;
        a = '0;
        a[MEM_ADDR_BITS-1:0]          = off[MEM_ADDR_BITS-1:0];
        a[SEL_LSB +: SEL_BITS]        = sel[SEL_BITS-1:0];
        a[ADDR_WIDTH-1 -: UPPER_BITS] = upper[UPPER_BITS-1:0];
        return a;
    endfunction

    // Half the traffic lands in a small window so partial strobes overlap
    function automatic addr_t random_addr();
        int word;
        word = next_rand(2) ? next_rand(32) : next_rand(MEM_SIZE / 4);
        return make_addr(next_rand(NO_MEMS), word * 4, 0);
    endfunction

    function automatic int byte_key(input addr_t a, input int b);
        return int'(a[SEL_LSB +: SEL_BITS]) * MEM_SIZE + int'(a[MEM_ADDR_BITS-1:0]) + b;
    endfunction

    function automatic void record_write(input addr_t a, input data_t d, input strb_t s);
        if (a[SEL_LSB +: SEL_BITS] < NO_MEMS) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (s[b]) model[byte_key(a, b)] = d[8*b +: 8];
            end
        end
    endfunction

    // Bytes never written read as zero, unmapped space always does
    function automatic data_t expected_word(input addr_t a);
        data_t w;
        w = '0;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (model.exists(byte_key(a, b))) w[8*b +: 8] = model[byte_key(a, b)];
        end
        return w;
    endfunction

    function automatic resp_t expected_resp(input addr_t a);
        return (a[SEL_LSB +: SEL_BITS] < NO_MEMS) ? RESP_OKAY : RESP_DECERR;
    endfunction

    // ********************
    // Bus tasks
    // ********************

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_stuck(input string what);
        $display("%s never completed, gave up at %0t ns", what, $time);
        errors++;
    endtask

    task automatic raise_write(input addr_t a, input data_t d, input strb_t s);
        @(posedge clk);
        aw_addr  <= a;
        w_data   <= d;
        w_strb   <= s;
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
    endtask

    task automatic await_write_accept();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (aw_ready && w_ready) break;
        end
        if (n == WAIT_LIMIT) report_stuck("The write address handshake");
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
    endtask

    task automatic take_write_resp(input int hold, input resp_t exp);
        int    n;
        resp_t seen;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (b_valid) break;
        end
        if (n == WAIT_LIMIT) begin
            report_stuck("The write response handshake");
            return;
        end
        seen = b_resp;
        for (int i = 0; i <= hold; i++) begin
            if (!b_valid || b_resp !== seen) report_error("b channel changed before b_ready");
            if (aw_valid && aw_ready) report_error("write address taken with b pending");
            @(posedge clk);
            if (i == hold) b_ready <= 1'b1;
            @(negedge clk);
        end
        if (!b_valid) report_error("b_valid dropped before b_ready");
        @(posedge clk);
        b_ready <= 1'b0;
        if (seen !== exp) report_error($sformatf("b_resp %0d, expected %0d", seen, exp));
    endtask

    task automatic raise_read(input addr_t a);
        @(posedge clk);
        ar_addr  <= a;
        ar_valid <= 1'b1;
    endtask

    task automatic await_read_accept();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (ar_ready) break;
        end
        if (n == WAIT_LIMIT) report_stuck("The read address handshake");
        @(posedge clk);
        ar_valid <= 1'b0;
    endtask

    task automatic take_read_resp(input int hold, input data_t exp, input resp_t exp_resp);
        int    n;
        data_t seen;
        resp_t seen_resp;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (r_valid) break;
        end
        if (n == WAIT_LIMIT) begin
            report_stuck("The read response handshake");
            return;
        end
        seen      = r_data;
        seen_resp = r_resp;
        for (int i = 0; i <= hold; i++) begin
            if (!r_valid || r_data !== seen || r_resp !== seen_resp) begin
                report_error("r channel changed before r_ready");
            end
            if (ar_valid && ar_ready) report_error("read address taken with r pending");
            @(posedge clk);
            if (i == hold) r_ready <= 1'b1;
            @(negedge clk);
        end
        if (!r_valid) report_error("r_valid dropped before r_ready");
        @(posedge clk);
        r_ready <= 1'b0;
        if (seen !== exp) report_error($sformatf("r_data %h, expected %h", seen, exp));
        if (seen_resp !== exp_resp) begin
            report_error($sformatf("r_resp %0d, expected %0d", seen_resp, exp_resp));
        end
    endtask

    task automatic do_write(input addr_t a, input data_t d, input strb_t s, input int hold);
        raise_write(a, d, s);
        await_write_accept();
        record_write(a, d, s);
        take_write_resp(hold, expected_resp(a));
    endtask

    task automatic do_read(input addr_t a, input int hold);
        raise_read(a);
        await_read_accept();
        take_read_resp(hold, expected_word(a), expected_resp(a));
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ********************
    // Tests
    // ********************

    task automatic mapped_traffic();
        addr_t pending [$];
        addr_t a;
        for (int i = 0; i < 200; i++) begin
            a = random_addr();
            do_write(a, rand_word(), strb_t'(next_rand(16)), 0);
            pending.push_back(a);
            if (pending.size() > next_rand(4)) do_read(pending.pop_front(), 0);
        end
        while (pending.size() > 0) do_read(pending.pop_front(), 0);
    endtask

    // A write to select 3 must leave every RAM untouched
    task automatic unmapped_access();
        addr_t a;
        int    off;
        for (int i = 0; i < 8; i++) begin
            off = next_rand(MEM_SIZE / 4) * 4;
            a   = make_addr(3, off, 0);
            do_write(a, rand_word() | 1, 4'hf, 0);
            do_read(a, 0);
            for (int s = 0; s < NO_MEMS; s++) do_read(make_addr(s, off, 0), 0);
        end
    endtask

    task automatic region_independence();
        data_t d;
        int    off;
        for (int i = 0; i < 6; i++) begin
            off = next_rand(MEM_SIZE / 4) * 4;
            d   = rand_word();
            for (int s = 0; s < NO_MEMS; s++) do_write(make_addr(s, off, 0), d + s, 4'hf, 0);
            for (int s = 0; s < NO_MEMS; s++) begin
                do_read(make_addr(s, off, 0), 0);
                do_read(make_addr(s, off, next_rand(32767) + 1), 0); // Alias address
            end
        end
    endtask

    task automatic back_pressure();
        addr_t a0, a1;
        data_t d0, d1, e0;
        strb_t s0, s1;
        for (int i = 0; i < 20; i++) begin
            a0 = random_addr();
            a1 = random_addr();
            d0 = rand_word();
            d1 = rand_word();
            s0 = strb_t'(next_rand(16));
            s1 = strb_t'(next_rand(16));
            raise_write(a0, d0, s0);
            await_write_accept();
            record_write(a0, d0, s0);
            raise_write(a1, d1, s1); // Must wait for the first b
            take_write_resp(next_rand(9), RESP_OKAY);
            await_write_accept();
            record_write(a1, d1, s1);
            take_write_resp(next_rand(9), RESP_OKAY);
            raise_read(a0);
            await_read_accept();
            e0 = expected_word(a0);
            raise_read(a1);
            take_read_resp(next_rand(9), e0, RESP_OKAY);
            await_read_accept();
            take_read_resp(next_rand(9), expected_word(a1), RESP_OKAY);
        end
    endtask

    task automatic pause_check();
        addr_t ra, ra2, wa;
        data_t wd, er;
        int    n;
        logic  aw_done, ar_done, aw_hit, ar_hit;
        ra  = make_addr(0, next_rand(32) * 4, 0);
        ra2 = make_addr(2, next_rand(32) * 4, 0);
        wa  = make_addr(1, next_rand(32) * 4, 0);
        wd  = rand_word();
        raise_read(ra);
        await_read_accept();
        er = expected_word(ra);
        @(posedge clk);
        pause_req <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (pause_ack) report_error("pause_ack high with a read outstanding");
        end
        take_read_resp(0, er, RESP_OKAY);
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (pause_ack) break;
        end
        if (n == WAIT_LIMIT) report_stuck("The pause acknowledge");
        raise_write(wa, wd, 4'hf);
        raise_read(ra2);
        repeat (4) begin
            @(negedge clk);
            if (!pause_ack) report_error("pause_ack fell while pause_req is high");
            if (aw_ready || w_ready || ar_ready) report_error("address ready while paused");
        end
        @(posedge clk);
        pause_req <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        if (pause_ack) report_error("pause_ack still high a cycle after pause_req fell");
        // Both requests are still raised here, at a falling edge
        aw_done = 1'b0;
        ar_done = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !(aw_done && ar_done); n++) begin
            aw_hit = aw_valid && aw_ready && w_ready;
            ar_hit = ar_valid && ar_ready;
            @(posedge clk);
            if (aw_hit) begin
                aw_valid <= 1'b0;
                w_valid  <= 1'b0;
                aw_done  = 1'b1;
            end
            if (ar_hit) begin
                ar_valid <= 1'b0;
                ar_done  = 1'b1;
            end
            @(negedge clk);
        end
        if (!aw_done) report_stuck("The write address handshake after the pause");
        if (!ar_done) report_stuck("The read address handshake after the pause");
        record_write(wa, wd, 4'hf);
        take_write_resp(0, RESP_OKAY);
        take_read_resp(0, expected_word(ra2), RESP_OKAY);
        do_read(wa, 0);
    endtask

    initial begin
        reset     <= 1'b1;
        aw_addr   <= '0;
        aw_valid  <= 1'b0;
        w_data    <= '0;
        w_strb    <= '0;
        w_valid   <= 1'b0;
        b_ready   <= 1'b0;
        ar_addr   <= '0;
        ar_valid  <= 1'b0;
        r_ready   <= 1'b0;
        pause_req <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        mapped_traffic();
        finish_test("Mapped writes and reads");
        unmapped_access();
        finish_test("Unmapped accesses");
        region_independence();
        finish_test("Region independence");
        back_pressure();
        finish_test("Back-pressure");
        pause_check();
        finish_test("Pause");

        $display("Tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
src/adam_pkg.sv
src/adam_axil_if.sv
src/adam_axil_ram.sv
src/adam_axil_demux.sv
src/adam_mem_sys.sv
test/adam_tb.sv

// File: Bender.yml
package:
  name: adam_mem_sys

sources:
  # Design
  - src/adam_pkg.sv
  - src/adam_axil_if.sv
  - src/adam_axil_ram.sv
  - src/adam_axil_demux.sv
  - src/adam_mem_sys.sv

  # Testbench
  - target: test
    files:
      - test/adam_tb.sv
